/* hdl/minimig_io_params.svh */
/*
  Minimig board I/O build constants
  Channel count and timing of debounce and LED stretch
*/

`ifndef MINIMIG_IO_PARAMS_SVH
`define MINIMIG_IO_PARAMS_SVH

// Ten switches then four keys
`define MINIMIG_IO_NUM_IN 14

// clk_28 cycles per debounce sample
`define MINIMIG_IO_TICK_DIV 8

// Ticks of agreement before the output follows
`define MINIMIG_IO_DEB_COUNT 4

// Cycles an activity LED stays lit
`define MINIMIG_IO_STRETCH_LEN 16

`endif

/* hdl/minimig_io_pkg.sv */
/*
  Minimig board I/O shared types
  Switch, key, display and config vectors
*/

`include "minimig_io_params.svh"

package minimig_io_pkg;

  typedef logic [9:0] sw_vec_t;    // SW9..SW0, high is on

  typedef logic [3:0] key_vec_t;   // KEY3..KEY0, low is pressed

  // Switches in bits 9..0, keys above
  typedef logic [`MINIMIG_IO_NUM_IN-1:0] in_vec_t;

  typedef logic [6:0] seg7_t;      // Segments g..a, active low

  typedef logic [7:0] track_t;     // Floppy track number

  typedef logic [3:0] ctrl_cfg_t;  // Control core config nibble

endpackage

/* hdl/debounce_tick.sv */
/*
  Debounce tick generator
  One-cycle sample strobe every MINIMIG_IO_TICK_DIV cycles
*/

`include "minimig_io_params.svh"

module debounce_tick (
  input  logic clk_28,  // System clock
  input  logic rst,     // Sync reset
  output logic tick     // Sample strobe
);

  localparam int unsigned DIV = `MINIMIG_IO_TICK_DIV;
  localparam int unsigned CW  = $clog2(DIV);
  localparam logic [CW-1:0] CNT_LAST = CW'(DIV - 1);

  logic [CW-1:0] div_cnt;  // Prescaler

  always_ff @(posedge clk_28) begin
    if (rst) begin
      div_cnt <= '0;
      tick    <= 1'b0;
    end else if (div_cnt == CNT_LAST) begin
      div_cnt <= '0;             // Wrap
      tick    <= 1'b1;           // Pulse once per period
    end else begin
      div_cnt <= div_cnt + 1'b1;
      tick    <= 1'b0;
    end
  end

endmodule

/* hdl/switch_debouncer.sv */
/*
  Switch debouncer
  Two-flop synchronizer and stable-count filter for one line
*/

`include "minimig_io_params.svh"

module switch_debouncer #(
  parameter logic RESET_LEVEL = 1'b0  // 1 for active-low keys
) (
  input  logic clk_28,  // System clock
  input  logic rst,     // Sync reset
  input  logic tick,    // Sample strobe
  input  logic raw,     // Board pin
  output logic level    // Debounced level
);

  localparam int unsigned DEB = `MINIMIG_IO_DEB_COUNT;
  localparam int unsigned CW  = $clog2(DEB + 1);
  localparam logic [CW-1:0] CNT_LAST = CW'(DEB - 1);

  logic [1:0]    sync_q;   // Synchronizer chain
  logic [CW-1:0] stable;   // Ticks with differing input

  ////////////////////
  // Synchronizer
  ////////////////////

  always_ff @(posedge clk_28) begin
    if (rst) sync_q <= {2{RESET_LEVEL}};  // Start idle, no false flip
    else     sync_q <= {sync_q[0], raw};
  end

  ////////////////////
  // Stable counter
  ////////////////////

  always_ff @(posedge clk_28) begin
    if (rst) begin
      stable <= '0;
      level  <= RESET_LEVEL;
    end else if (sync_q[1] == level) begin
      stable <= '0;                  // Agreement clears the run
    end else if (tick) begin
      if (stable == CNT_LAST) begin
        stable <= '0;
        level  <= sync_q[1];         // New value held long enough
      end else begin
        stable <= stable + 1'b1;
      end
    end
  end

endmodule

/* hdl/board_config.sv */
/*
  Board configuration decoder
  Debounced switches and keys to config levels, UART steering
*/

module board_config import minimig_io_pkg::*; (
  input  in_vec_t   debounced,     // Conditioned switches and keys
  // UART
  input  logic      uart_rxd,      // Board serial in
  input  logic      ctrl_txd,      // Control core serial out
  input  logic      minimig_txd,   // Emulated port serial out
  output logic      uart_txd,      // Board serial out
  output logic      minimig_rxd,   // Emulated port serial in
  // Config
  output ctrl_cfg_t ctrl_cfg,      // Control core config
  output logic      audio_exchan,  // Swap left and right
  output logic      audio_mix,     // Blend channels
  output logic      joy_emu_en,    // Keyboard joystick emulation
  output logic      scan_15khz,    // Scandoubler disable
  output logic      mouse_btn1,    // Active low
  output logic      mouse_btn2,    // Active low
  output logic      rst_ext        // External reset request
);

  // Key lines sit above the switches
  localparam int unsigned KEY_BASE = $bits(sw_vec_t);

  logic uart_sel;  // High routes the board UART to the control core

  ////////////////////
  // Switches
  ////////////////////

  assign scan_15khz   = debounced[9];
  assign joy_emu_en   = debounced[8];
  assign audio_exchan = debounced[7];
  assign audio_mix    = debounced[6];
  assign uart_sel     = debounced[5];
  assign ctrl_cfg     = debounced[4:1];  // SW4..SW1

  ////////////////////
  // Keys
  ////////////////////

  assign mouse_btn1 = debounced[KEY_BASE + 3];
  assign mouse_btn2 = debounced[KEY_BASE + 2];
  assign rst_ext    = ~debounced[KEY_BASE + 0];  // Pressed KEY0 resets

  // UART steering, emulated port idles high while detached
  assign uart_txd    = uart_sel ? ctrl_txd : minimig_txd;
  assign minimig_rxd = uart_sel ? 1'b1     : uart_rxd;

endmodule

/* hdl/activity_display.sv */
/*
  Activity display
  Track number on two hex digits, stretched FIFO activity and status LEDs
*/

`include "minimig_io_params.svh"

module activity_display import minimig_io_pkg::*; (
  input  logic       clk_28,       // System clock
  input  logic       rst,          // Sync reset
  input  track_t     track,        // Floppy track number
  input  logic       floppy_fwr,   // Floppy FIFO write strobe
  input  logic       floppy_frd,   // Floppy FIFO read strobe
  input  logic       hd_fwr,       // HD FIFO write strobe
  input  logic       hd_frd,       // HD FIFO read strobe
  input  logic [2:0] status,       // ROM, RAM, REG
  input  logic [3:0] ctrl_status,  // Control core LEDs
  output seg7_t      hex_0,        // Low nibble digit
  output seg7_t      hex_1,        // High nibble digit
  output logic [7:0] led_g,        // Green LEDs
  output logic [3:0] led_r         // Red LEDs
);

  localparam int unsigned SL = `MINIMIG_IO_STRETCH_LEN;
  localparam int unsigned CW = $clog2(SL + 1);
  localparam logic [CW-1:0] STRETCH_LOAD = CW'(SL);

  localparam seg7_t SEG_BLANK = 7'h7f;  // All segments off

  logic [3:0]    strobe;               // Activity strobes in LED order
  logic [CW-1:0] stretch_cnt [4];      // Remaining lit cycles
  logic [2:0]    status_q;
  logic [3:0]    ctrl_status_q;

  // Hex nibble to segments with bit 0 as segment a
  function automatic seg7_t seg_decode(input logic [3:0] nib);
    seg7_t seg;
    case (nib)
      4'h0: seg = 7'h40;
      4'h1: seg = 7'h79;
      4'h2: seg = 7'h24;
      4'h3: seg = 7'h30;
      4'h4: seg = 7'h19;
      4'h5: seg = 7'h12;
      4'h6: seg = 7'h02;
      4'h7: seg = 7'h78;
      4'h8: seg = 7'h00;
      4'h9: seg = 7'h10;
      4'ha: seg = 7'h08;
      4'hb: seg = 7'h03;
      4'hc: seg = 7'h46;
      4'hd: seg = 7'h21;
      4'he: seg = 7'h06;
      default: seg = 7'h0e;  // F
    endcase
    return seg;
  endfunction

  ////////////////////
  // Track digits
  ////////////////////

  always_ff @(posedge clk_28) begin
    if (rst) begin
      hex_0 <= SEG_BLANK;
      hex_1 <= SEG_BLANK;
    end else begin
      hex_0 <= seg_decode(track[3:0]);
      hex_1 <= seg_decode(track[7:4]);
    end
  end

  ////////////////////
  // Activity stretch
  ////////////////////

  assign strobe = {hd_frd, hd_fwr, floppy_frd, floppy_fwr};

  always_ff @(posedge clk_28) begin
    for (int i = 0; i < 4; i++) begin
      if (rst)                     stretch_cnt[i] <= '0;
      else if (strobe[i])          stretch_cnt[i] <= STRETCH_LOAD;  // Restart on any strobe
      else if (stretch_cnt[i] != 0) stretch_cnt[i] <= stretch_cnt[i] - 1'b1;
    end
  end

  // Status registers one cycle behind the inputs
  always_ff @(posedge clk_28) begin
    if (rst) begin
      status_q      <= '0;
      ctrl_status_q <= '0;
    end else begin
      status_q      <= status;
      ctrl_status_q <= ctrl_status;
    end
  end

  assign led_g = {1'b0,                     // Unused
                  status_q,                 // ROM, RAM, REG
                  (stretch_cnt[3] != 0),    // Lit while counting
                  (stretch_cnt[2] != 0),
                  (stretch_cnt[1] != 0),
                  (stretch_cnt[0] != 0)};
  assign led_r = ctrl_status_q;

endmodule

/* hdl/minimig_io_top.sv */
/*
  Minimig board I/O top
  Input conditioning, config decode, UART steering and activity display
*/

`include "minimig_io_params.svh"

module minimig_io_top import minimig_io_pkg::*; (
  input  logic       clk_28,        // System clock
  input  logic       rst,           // Sync reset
  // Board inputs
  input  sw_vec_t    sw,            // Toggle switches
  input  key_vec_t   key,           // Push buttons, active low
  // UART
  input  logic       uart_rxd,
  input  logic       ctrl_txd,
  input  logic       minimig_txd,
  output logic       uart_txd,
  output logic       minimig_rxd,
  // Config
  output ctrl_cfg_t  ctrl_cfg,
  output logic       audio_exchan,
  output logic       audio_mix,
  output logic       joy_emu_en,
  output logic       scan_15khz,
  output logic       mouse_btn1,
  output logic       mouse_btn2,
  output logic       rst_ext,
  // Activity sources
  input  track_t     track,
  input  logic       floppy_fwr,
  input  logic       floppy_frd,
  input  logic       hd_fwr,
  input  logic       hd_frd,
  input  logic [2:0] status,        // ROM, RAM, REG
  input  logic [3:0] ctrl_status,
  // Indicators
  output seg7_t      hex_0,
  output seg7_t      hex_1,
  output logic [7:0] led_g,
  output logic [3:0] led_r
);

  localparam int unsigned NUM_SW = $bits(sw_vec_t);

  logic    tick;       // Shared sample strobe
  in_vec_t raw_in;     // Keys above switches
  in_vec_t debounced;

  assign raw_in = {key, sw};

  ////////////////////
  // Conditioning
  ////////////////////

  debounce_tick u_tick (
    .clk_28 (clk_28),
    .rst    (rst),
    .tick   (tick)
  );

  for (genvar i = 0; i < `MINIMIG_IO_NUM_IN; i++) begin : g_deb
    switch_debouncer #(
      .RESET_LEVEL ((i >= NUM_SW) ? 1'b1 : 1'b0)  // Keys rest released
    ) u_deb (
      .clk_28 (clk_28),
      .rst    (rst),
      .tick   (tick),
      .raw    (raw_in[i]),
      .level  (debounced[i])
    );
  end

  board_config u_cfg (
    .debounced    (debounced),
    .uart_rxd     (uart_rxd),
    .ctrl_txd     (ctrl_txd),
    .minimig_txd  (minimig_txd),
    .uart_txd     (uart_txd),
    .minimig_rxd  (minimig_rxd),
    .ctrl_cfg     (ctrl_cfg),
    .audio_exchan (audio_exchan),
    .audio_mix    (audio_mix),
    .joy_emu_en   (joy_emu_en),
    .scan_15khz   (scan_15khz),
    .mouse_btn1   (mouse_btn1),
    .mouse_btn2   (mouse_btn2),
    .rst_ext      (rst_ext)
  );

  ////////////////////
  // Indicators
  ////////////////////

  activity_display u_disp (
    .clk_28      (clk_28),
    .rst         (rst),
    .track       (track),
    .floppy_fwr  (floppy_fwr),
    .floppy_frd  (floppy_frd),
    .hd_fwr      (hd_fwr),
    .hd_frd      (hd_frd),
    .status      (status),
    .ctrl_status (ctrl_status),
    .hex_0       (hex_0),
    .hex_1       (hex_1),
    .led_g       (led_g),
    .led_r       (led_r)
  );

endmodule

/* tb/tb_minimig_io.sv */
/*
  Testbench for the Minimig board I/O block
  Table-driven config, glitch, UART, track display and LED checks
*/

`include "minimig_io_params.svh"

module tb_minimig_io
  import minimig_io_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned SL         = `MINIMIG_IO_STRETCH_LEN;
  localparam int unsigned NUM_ROWS   = 5;
  localparam int unsigned WAIT_LIMIT = 200;  // Cycles, far past debounce latency

  // Active-low digits F..0, bit 0 is segment a
  localparam logic [16*7-1:0] SEG_ROM = {
    7'h0e, 7'h06, 7'h21, 7'h46, 7'h03, 7'h08, 7'h10, 7'h00,
    7'h78, 7'h02, 7'h12, 7'h19, 7'h30, 7'h24, 7'h79, 7'h40
  };

  // Row columns: sw, key, track, strobes, cfg, {scan,joy,exch,mix}, {btn1,btn2,rst_ext}
  typedef struct packed {
    logic [9:0] sw;
    logic [3:0] key;
    logic [7:0] track;
    logic [3:0] strb;
    logic [3:0] cfg;
    logic [3:0] flags;
    logic [2:0] keys;
  } row_t;

  logic clk_28, rst;
  sw_vec_t sw;
  key_vec_t key;
  logic uart_rxd, ctrl_txd, minimig_txd, uart_txd, minimig_rxd;
  ctrl_cfg_t ctrl_cfg;
  logic audio_exchan, audio_mix, joy_emu_en, scan_15khz;
  logic mouse_btn1, mouse_btn2, rst_ext;
  track_t track;
  logic floppy_fwr, floppy_frd, hd_fwr, hd_frd;
  logic [2:0] status;
  logic [3:0] ctrl_status;
  seg7_t hex_0, hex_1;
  logic [7:0] led_g;
  logic [3:0] led_r;

  logic [3:0]  strb;                  // Activity strobes in LED order
  row_t        rows [NUM_ROWS];
  logic [15:0] lfsr;
  int          err_cnt, timeout_cnt;
  int          ref_cnt [4];           // Reference stretch counters
  logic [2:0]  status_exp;
  logic [3:0]  ctrl_exp;
  seg7_t       hex0_exp, hex1_exp;

  assign {hd_frd, hd_fwr, floppy_frd, floppy_fwr} = strb;

  minimig_io_top DUT (.*);

  always #2 clk_28 = ~clk_28;  // 4 ns period

  ////////////////////
  // Reference model
  ////////////////////

  always @(posedge clk_28) begin
    for (int i = 0; i < 4; i++) begin
      if (rst)                ref_cnt[i] <= 0;
      else if (strb[i])       ref_cnt[i] <= SL;              // Restart on strobe
      else if (ref_cnt[i] != 0) ref_cnt[i] <= ref_cnt[i] - 1;
    end
    status_exp <= rst ? 3'b000 : status;
    ctrl_exp   <= rst ? 4'h0   : ctrl_status;
    hex0_exp   <= rst ? 7'h7f  : SEG_ROM[track[3:0]*7 +: 7];  // Blank in reset
    hex1_exp   <= rst ? 7'h7f  : SEG_ROM[track[7:4]*7 +: 7];
  end

  ////////////////////
  // Helpers
  ////////////////////

  // Galois LFSR, one step per bit
  function automatic logic rand_bit();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) lfsr = lfsr ^ 16'hb400;
    return out;
  endfunction

  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[6:0], rand_bit()};
    return v;
  endfunction

  task automatic report_mismatch(input string name, input logic [15:0] exp,
                                 input logic [15:0] act);
    err_cnt++;
    $display("ERROR at %0t ns: %s expected %h got %h", $time, name, exp, act);
  endtask

  task automatic check_display();
    for (int i = 0; i < 4; i++) begin
      if (led_g[i] !== (ref_cnt[i] != 0))
        report_mismatch($sformatf("led_g[%0d]", i), ref_cnt[i] != 0, led_g[i]);
    end
    if (led_g[6:4] !== status_exp) report_mismatch("led_g[6:4]", status_exp, led_g[6:4]);
    if (led_g[7] !== 1'b0) report_mismatch("led_g[7]", 1'b0, led_g[7]);
    if (led_r !== ctrl_exp) report_mismatch("led_r", ctrl_exp, led_r);
    if (hex_0 !== hex0_exp) report_mismatch("hex_0", hex0_exp, hex_0);
    if (hex_1 !== hex1_exp) report_mismatch("hex_1", hex1_exp, hex_1);
  endtask

  // Leaves the caller 1 ns past the edge, ready to drive
  task automatic next_cycle();
    @(posedge clk_28);
    #1;
    check_display();
  endtask

  function automatic logic cfg_match(input row_t r);
    return {ctrl_cfg, scan_15khz, joy_emu_en, audio_exchan, audio_mix,
            mouse_btn1, mouse_btn2, rst_ext} === {r.cfg, r.flags, r.keys};
  endfunction

  task automatic check_cfg(input row_t r);
    if (ctrl_cfg !== r.cfg) report_mismatch("ctrl_cfg", r.cfg, ctrl_cfg);
    if (scan_15khz !== r.flags[3]) report_mismatch("scan_15khz", r.flags[3], scan_15khz);
    if (joy_emu_en !== r.flags[2]) report_mismatch("joy_emu_en", r.flags[2], joy_emu_en);
    if (audio_exchan !== r.flags[1]) report_mismatch("audio_exchan", r.flags[1], audio_exchan);
    if (audio_mix !== r.flags[0]) report_mismatch("audio_mix", r.flags[0], audio_mix);
    if (mouse_btn1 !== r.keys[2]) report_mismatch("mouse_btn1", r.keys[2], mouse_btn1);
    if (mouse_btn2 !== r.keys[1]) report_mismatch("mouse_btn2", r.keys[1], mouse_btn2);
    if (rst_ext !== r.keys[0]) report_mismatch("rst_ext", r.keys[0], rst_ext);
  endtask

  task automatic apply_row(input row_t r);
    sw    = r.sw;
    key   = r.key;
    track = r.track;
    strb  = r.strb;             // One-cycle burst
    for (int n = 0; n < WAIT_LIMIT; n++) begin
      next_cycle();
      strb = 4'h0;
      if (cfg_match(r)) break;
    end
    if (!cfg_match(r)) begin
      timeout_cnt++;
      $display("Timeout at %0t ns: config outputs did not settle for sw %h key %h",
               $time, r.sw, r.key);
    end
    check_cfg(r);
  endtask

  task automatic wait_uart_sel(input logic sel);
    ctrl_txd    = 1'b1;         // Distinct levels expose the selection
    minimig_txd = 1'b0;
    for (int n = 0; n < WAIT_LIMIT; n++) begin
      next_cycle();
      if (uart_txd === sel) break;
    end
    if (uart_txd !== sel) begin
      timeout_cnt++;
      $display("Timeout at %0t ns: UART select never switched to %0d", $time, sel);
    end
  endtask

  task automatic check_uart(input logic sel);
    logic [2:0] v;
    for (int i = 0; i < 8; i++) begin
      v           = i[2:0];
      uart_rxd    = v[2];
      ctrl_txd    = v[1];
      minimig_txd = v[0];
      #1;
      if (uart_txd !== (sel ? v[1] : v[0]))
        report_mismatch("uart_txd", sel ? v[1] : v[0], uart_txd);
      if (minimig_rxd !== (sel ? 1'b1 : v[2]))
        report_mismatch("minimig_rxd", sel ? 1'b1 : v[2], minimig_rxd);
      next_cycle();
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    lfsr        = 16'd37;
    err_cnt     = 0;
    timeout_cnt = 0;
    clk_28      = 1'b0;
    rst         = 1'b1;
    sw          = '0;
    key         = '1;          // Released
    uart_rxd    = 1'b1;
    ctrl_txd    = 1'b1;
    minimig_txd = 1'b1;
    track       = '0;
    strb        = '0;
    status      = '0;
    ctrl_status = '0;

    rows[0] = {10'h000, 4'hf, 8'h00, 4'h0, 4'h0, 4'b0000, 3'b110};
    rows[1] = {10'h3ff, 4'h0, 8'h4f, 4'hf, 4'hf, 4'b1111, 3'b001};
    rows[2] = {10'h296, 4'h7, 8'h9c, 4'h5, 4'hb, 4'b1010, 3'b010};
    rows[3] = {10'h169, 4'ha, 8'ha7, 4'ha, 4'h4, 4'b0101, 3'b101};
    rows[4] = {10'h000, 4'hf, 8'h3c, 4'h0, 4'h0, 4'b0000, 3'b110};

    repeat (16) @(posedge clk_28);
    #1;
    rst = 1'b0;

    // Idle state straight out of reset
    if (hex_0 !== 7'h7f) report_mismatch("hex_0", 7'h7f, hex_0);
    if (hex_1 !== 7'h7f) report_mismatch("hex_1", 7'h7f, hex_1);
    if (led_g !== 8'h00) report_mismatch("led_g", 8'h00, led_g);
    if (led_r !== 4'h0) report_mismatch("led_r", 4'h0, led_r);
    if (mouse_btn1 !== 1'b1) report_mismatch("mouse_btn1", 1'b1, mouse_btn1);
    if (mouse_btn2 !== 1'b1) report_mismatch("mouse_btn2", 1'b1, mouse_btn2);
    if (rst_ext !== 1'b0) report_mismatch("rst_ext", 1'b0, rst_ext);
    check_uart(1'b0);

    for (int r = 0; r < NUM_ROWS; r++) apply_row(rows[r]);

    // Short SW9 pulse must be filtered out
    sw[9] = 1'b1;
    next_cycle();
    next_cycle();
    sw[9] = 1'b0;
    for (int i = 0; i < 64; i++) begin
      next_cycle();
      if (scan_15khz !== 1'b0) report_mismatch("scan_15khz", 1'b0, scan_15khz);
    end

    sw[5] = 1'b1;               // Board UART to control core
    wait_uart_sel(1'b1);
    check_uart(1'b1);
    sw[5] = 1'b0;
    wait_uart_sel(1'b0);
    check_uart(1'b0);

    // Random activity, then a quiet tail to watch the LEDs decay
    for (int c = 0; c < 64; c++) begin
      if (c < 40) strb = 4'(rand_bits(4) & rand_bits(4) & rand_bits(4));
      else        strb = 4'h0;
      status      = 3'(rand_bits(3));
      ctrl_status = 4'(rand_bits(4));
      track       = rand_bits(8);
      next_cycle();
    end

    $display("Value errors: %0d, timeouts: %0d", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+hdl
hdl/minimig_io_pkg.sv
hdl/debounce_tick.sv
hdl/switch_debouncer.sv
hdl/board_config.sv
hdl/activity_display.sv
hdl/minimig_io_top.sv
tb/tb_minimig_io.sv

/* Bender.yml */
package:
  name: minimig_io

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/minimig_io_pkg.sv
      - hdl/debounce_tick.sv
      - hdl/switch_debouncer.sv
      - hdl/board_config.sv
      - hdl/activity_display.sv
      - hdl/minimig_io_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - tb/tb_minimig_io.sv
